// ==== all.f ====
+incdir+rtl
rtl/cuPkg.sv
rtl/instrDecoder.sv
rtl/controlSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
testbench/controlUnitTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run with Verilator, then search the log for the failure line
rm -rf obj_dir sim.log
verilator --binary --assert -f all.f --top-module controlUnitTb -Mdir obj_dir \
	&& ./obj_dir/VcontrolUnitTb 2>&1 | tee sim.log \
	|| { echo "Build or run did not complete"; exit 1; }
grep -q "Verification failed" sim.log \
	&& { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation done without failures"; exit 0; }

// ==== testbench/controlUnitTb.sv ====
`include "cu_defs.svh"

module controlUnitTb;

	localparam int clkPeriod = 20;
	localparam int numInstr  = 300;
	localparam int maxIdle   = 8;   // Idle cycles tolerated between two strobes

	// Strobe vector {ir, npc, pc, mdr, mar, reg, ram, psr}
	localparam logic [7:0] enIr  = 8'h80;
	localparam logic [7:0] enNpc = 8'h40;
	localparam logic [7:0] enPc  = 8'h20;
	localparam logic [7:0] enMdr = 8'h10;
	localparam logic [7:0] enMar = 8'h08;
	localparam logic [7:0] enReg = 8'h04;
	localparam logic [7:0] enRam = 8'h02;
	localparam logic [7:0] enPsr = 8'h01;

	logic             Clk;
	logic             RESET;
	cuPkg::word_t     irOut;
	logic             mfc;
	logic             cond;
	logic             branchAlways;
	logic             branchNever;
	cuPkg::ctrlWord_t ctrl;

	integer          seed;
	logic [7:0]      strobes;
	logic [7:0]      expEvents[$];   // Expected strobe cycles of the current class
	string           className;
	logic            isArith;
	logic            isMem;
	cuPkg::regAddr_t expRegC;
	cuPkg::regAddr_t expRs1;
	cuPkg::op3_t     expOp3;

	controlUnit u_controlUnit (
		.Clk          (Clk),
		.RESET        (RESET),
		.irOut        (irOut),
		.mfc          (mfc),
		.cond         (cond),
		.branchAlways (branchAlways),
		.branchNever  (branchNever),
		.ctrl         (ctrl)
	);

	always #(clkPeriod / 2) Clk = ~Clk;

	assign strobes = {ctrl.irEnable, ctrl.npcEnable, ctrl.pcEnable, ctrl.mdrEnable,
		ctrl.marEnable, ctrl.regWrite, ctrl.ramEnable, ctrl.psrEnable};

	task automatic failValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
		$display("Verification failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic failPlain(input string what);
		$display("ERROR %s", what);
		$display("Verification failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected) else failValue(testName, expected, actual);
	endtask

	// Clears up and every strobe low while reset is held
	assert property (@(negedge Clk) RESET |-> (ctrl.pcClear && ctrl.psrClear && strobes == 8'h00))
		else failPlain("clears or enables wrong while RESET was high");

	assert property (@(posedge Clk) (ctrl.ramEnable && mfc) |=> ctrl.irEnable)
		else failPlain("irEnable did not follow the cycle in which mfc was sampled");

	task automatic observe();
		@(negedge Clk);
		assert (!ctrl.pcClear && !ctrl.psrClear) else failPlain("a clear was active after reset");
	endtask

	// Skips idle cycles up to the next cycle with any strobe
	task automatic nextEvent(output logic [7:0] ev);
		int gap;
		gap = 0;
		do
		begin
			observe();
			gap++;
			assert (gap <= maxIdle) else failPlain({className, " stalled with no strobe"});
		end
		while (strobes == 8'h00);
		ev = strobes;
	endtask

	// Random word of one kept class and its expected strobe sequence
	task automatic loadInstruction();
		cuPkg::word_t word;
		logic [31:0]  rnd;
		logic         taken;
		logic         annulled;
		word = $random(seed);
		rnd  = $random(seed);
		case (rnd[4:3])
			2'd1:
			begin
				cond = 1'b1;   // Branch always
				branchAlways = 1'b1;
				branchNever = 1'b0;
			end
			2'd2:
			begin
				cond = 1'b1;
				branchAlways = 1'b0;
				branchNever = 1'b1;
			end
			default:
			begin
				cond = rnd[5];
				branchAlways = 1'b0;
				branchNever = 1'b0;
			end
		endcase
		isArith = 1'b0;
		isMem = 1'b0;
		expEvents.delete();
		case (rnd[2:0])
			3'd0:
			begin
				word[31:30] = 2'b00;
				word[24:22] = 3'b100;   // SETHI
				className = "sethi";
				expEvents = '{enReg, enPc | enNpc};
			end
			3'd1, 3'd2:
			begin
				word[31:30] = 2'b00;
				word[24:22] = 3'b010;   // Bicc
				taken = cond && !branchNever;
				annulled = word[29] && (branchAlways || !taken);
				if (annulled)
				begin
					className = "branch annulled";
					expEvents = '{enNpc, enPc, enNpc};
				end
				else if (taken || branchNever)
				begin
					className = taken ? "branch taken" : "branch never";
					expEvents = '{enPc | enNpc};
				end
				else
				begin
					className = "branch not taken";
					expEvents = '{enPc, enNpc};
				end
			end
			3'd3:
			begin
				word[31:30] = 2'b01;
				className = "call";
				expEvents = '{enPc | enReg, enNpc};
			end
			3'd4:
			begin
				word[31:30] = 2'b10;
				word[24:19] = 6'b111000;
				className = "jmpl";
				expEvents = '{enReg, enPc, enNpc};
			end
			3'd5:
			begin
				word[31:30] = 2'b10;
				word[24] = 1'b0;   // ALU ops and their cc forms
				className = "arith";
				isArith = 1'b1;
				expEvents = '{enReg | (word[23] ? enPsr : 8'h00), enPc | enNpc};
			end
			3'd6:
			begin
				word[31:30] = 2'b11;
				case (rnd[10:8])
					3'd0: word[24:19] = 6'b000000;   // LD
					3'd1: word[24:19] = 6'b000001;   // LDUB
					3'd2: word[24:19] = 6'b000010;   // LDUH
					3'd3: word[24:19] = 6'b001001;   // LDSB
					default: word[24:19] = 6'b001010;   // LDSH
				endcase
				className = "load";
				isMem = 1'b1;
				expEvents = '{enMar, enRam, enMdr, enReg, enPc | enNpc};
			end
			default:
			begin
				word[31:30] = 2'b11;
				case (rnd[10:8])
					3'd0: word[24:19] = 6'b000100;   // ST
					3'd1: word[24:19] = 6'b000101;   // STB
					3'd2: word[24:19] = 6'b000110;   // STH
					3'd3: word[24:19] = 6'b000011;   // LDD
					3'd4: word[24:19] = 6'b000111;   // STD
					3'd5: word[24:19] = 6'b001101;   // LDSTUB
					default: word[24:19] = 6'b001111;   // SWAP
				endcase
				isMem = (rnd[10:8] < 3'd3);
				className = isMem ? "store" : "memory no-op";
				if (isMem)
					expEvents = '{enMar, enMdr, enRam, enPc | enNpc};
				else
					expEvents = '{enPc | enNpc};
			end
		endcase
		expRegC = (rnd[2:0] == 3'd3) ? `CU_LINK_REG : word[29:25];
		expRs1 = word[18:14];
		expOp3 = word[24:19];
		irOut = word;
	endtask

	// Entered with the fetch marEnable already seen
	task automatic fetchInstruction();
		int delay;
		observe();
		checkValue("fetch ramEnable after marEnable", 32'(enRam), 32'(strobes));
		checkValue("fetch ramOpcode", 32'(`CU_RAM_LOAD_WORD), 32'(ctrl.ramOpcode));
		delay = $unsigned($random(seed)) % 6;
		for (int j = 0; j <= delay; j++)
		begin
			observe();
			checkValue("fetch ramEnable held", 32'(enRam), 32'(strobes));
			if (j == delay)
				mfc = 1'b1;
		end
		observe();
		checkValue("fetch irEnable after mfc", 32'(enIr), 32'(strobes));
		mfc = 1'b0;
		loadInstruction();
	endtask

	task automatic runClass();
		logic [7:0] ev;
		logic [7:0] expected;
		while (expEvents.size() > 0)
		begin
			expected = expEvents.pop_front();
			nextEvent(ev);
			checkValue({className, " strobe order"}, 32'(expected), 32'(ev));
			if ((ev & enReg) != 8'h00 && !isArith)
				checkValue({className, " regC"}, 32'(expRegC), 32'(ctrl.regC));
			if ((ev & enReg) != 8'h00 && isArith)
			begin
				checkValue("arith regC", 32'(expRegC), 32'(ctrl.regC));
				checkValue("arith regA", 32'(expRs1), 32'(ctrl.regA));
				checkValue("arith aluOp", 32'(expOp3), 32'(ctrl.aluOp));
			end
			if (isMem && ev != (enPc | enNpc))
				checkValue({className, " ramOpcode"}, 32'(expOp3), 32'(ctrl.ramOpcode));
		end
		nextEvent(ev);
		checkValue({className, " then fetch"}, 32'(enMar), 32'(ev));
	endtask

	initial
	begin
		int npcCount;
		Clk = 1'b0;
		RESET = 1'b1;
		irOut = '0;
		mfc = 1'b0;
		cond = 1'b0;
		branchAlways = 1'b0;
		branchNever = 1'b0;
		seed = 73507;
		npcCount = 0;
		className = "reset";
		repeat (3)
		begin
			@(negedge Clk);
			checkValue("reset clears", 32'h3, 32'({ctrl.pcClear, ctrl.psrClear}));
			checkValue("reset enables", 32'h0, 32'(strobes));
		end
		RESET = 1'b0;
		// PC/nPC set up before the first fetch
		for (int i = 0; i < 3; i++)
		begin
			observe();
			if (strobes != 8'h00)
			begin
				checkValue("reset npcEnable", 32'(enNpc), 32'(strobes));
				npcCount++;
			end
		end
		checkValue("reset npcEnable count", 32'd1, 32'(npcCount));
		observe();
		checkValue("first marEnable after reset", 32'(enMar), 32'(strobes));
		for (int n = 0; n < numInstr; n++)
		begin
			fetchInstruction();
			runClass();
		end
		$display("Verification passed");
		$finish;
	end

	// Watchdog allows 40 cycles per instruction plus reset
	initial
	begin
		#((numInstr * 40 + 10) * clkPeriod);
		$display("ERROR watchdog expired before all instructions completed");
		$display("Verification failed");
		$fatal(1, "Timeout");
	end

endmodule

// ==== rtl/controlUnit.sv ====
module controlUnit (
	input  logic             Clk,
	input  logic             RESET,
	input  cuPkg::word_t     irOut,
	input  logic             mfc,
	input  logic             cond,
	input  logic             branchAlways,
	input  logic             branchNever,
	output cuPkg::ctrlWord_t ctrl
);

	cuPkg::instFields_t fields;
	cuPkg::instClass_t  instClass;
	cuPkg::cuState_t    state;

	instrDecoder u_instrDecoder (
		.irOut     (irOut),
		.fields    (fields),
		.instClass (instClass)
	);

	controlSequencer u_controlSequencer (
		.Clk          (Clk),
		.RESET        (RESET),
		.instClass    (instClass),
		.immediate    (fields.immediate),
		.annul        (fields.annul),
		.mfc          (mfc),
		.cond         (cond),
		.branchAlways (branchAlways),
		.branchNever  (branchNever),
		.state        (state)
	);

	controlWordGen u_controlWordGen (
		.state  (state),
		.fields (fields),
		.ctrl   (ctrl)
	);

endmodule

// ==== rtl/controlWordGen.sv ====
`include "cu_defs.svh"

module controlWordGen (
	input  cuPkg::cuState_t    state,
	input  cuPkg::instFields_t fields,
	output cuPkg::ctrlWord_t   ctrl
);

	always_comb
	begin
		ctrl           = '0;
		ctrl.aluOp     = `CU_ALU_ADD;
		ctrl.ramOpcode = `CU_RAM_LOAD_WORD;
		ctrl.regA      = `CU_ZERO_REG;
		ctrl.regB      = `CU_ZERO_REG;
		ctrl.regC      = `CU_ZERO_REG;

		// Routing stays stable across a setup state and its strobe state
		case (state)
			cuPkg::InitCalc, cuPkg::InitNpc:
			begin
				ctrl.aluASel = `CU_ALUA_PC;   // PC just cleared, so nPC = 4
				ctrl.aluBSel = `CU_ALUB_FOUR;
			end
			cuPkg::FetchAddr, cuPkg::MarLoad:
			begin
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_PC;
			end
			cuPkg::PcAdvCalc, cuPkg::PcAdvLoad, cuPkg::BrAnnulCalc, cuPkg::BrAnnulNpc,
			cuPkg::BrAnnulPc, cuPkg::BrAnnulNpc2, cuPkg::BrSkipPc, cuPkg::BrSkipNpc:
			begin
				ctrl.aluASel = `CU_ALUA_NPC;
				ctrl.aluBSel = `CU_ALUB_FOUR;
				ctrl.pcInSel = `CU_PCIN_NPC;
			end
			cuPkg::SethiCalc, cuPkg::SethiWrite:
			begin
				ctrl.extSel  = `CU_EXT_IMM22;
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_EXT;
				ctrl.regC    = fields.rd;
			end
			cuPkg::BrTakenCalc, cuPkg::BrTakenLoad:
			begin
				ctrl.extSel  = `CU_EXT_DISP22;   // PC-relative target
				ctrl.aluASel = `CU_ALUA_PC;
				ctrl.aluBSel = `CU_ALUB_EXT;
				ctrl.pcInSel = `CU_PCIN_NPC;
			end
			cuPkg::CallCalc, cuPkg::CallLoad:
			begin
				ctrl.regC    = `CU_LINK_REG;
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_PC;
				ctrl.pcInSel = `CU_PCIN_NPC;
			end
			cuPkg::CallTarget, cuPkg::CallNpc:
			begin
				ctrl.regA    = `CU_LINK_REG;   // Old PC now sits in r15
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.extSel  = `CU_EXT_DISP30;
				ctrl.aluBSel = `CU_ALUB_EXT;
			end
			cuPkg::JmplLink, cuPkg::JmplWrite:
			begin
				ctrl.regC    = fields.rd;
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_PC;
			end
			cuPkg::JmplPc:
				ctrl.pcInSel = `CU_PCIN_NPC;
			cuPkg::ArithImm, cuPkg::ArithImmWrite:
			begin
				ctrl.regC    = fields.rd;
				ctrl.regA    = fields.rs1;
				ctrl.aluOp   = fields.op3;
				ctrl.extSel  = `CU_EXT_SIMM13;
				ctrl.aluBSel = `CU_ALUB_EXT;
			end
			cuPkg::ArithReg, cuPkg::ArithRegWrite:
			begin
				ctrl.regC    = fields.rd;
				ctrl.regA    = fields.rs1;
				ctrl.regB    = fields.rs2;
				ctrl.aluOp   = fields.op3;
				ctrl.aluBSel = `CU_ALUB_REGB;
			end
			// Address rs1 + simm13
			cuPkg::JmplImm, cuPkg::JmplImmNpc, cuPkg::LoadImm, cuPkg::LoadImmMar,
			cuPkg::StoreImm, cuPkg::StoreImmMar:
			begin
				ctrl.regA    = fields.rs1;
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.extSel  = `CU_EXT_SIMM13;
				ctrl.aluBSel = `CU_ALUB_EXT;
			end
			// Address rs1 + rs2
			cuPkg::JmplReg, cuPkg::JmplRegNpc, cuPkg::LoadReg, cuPkg::LoadRegMar,
			cuPkg::StoreReg, cuPkg::StoreRegMar:
			begin
				ctrl.regA    = fields.rs1;
				ctrl.regB    = fields.rs2;
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_REGB;
			end
			cuPkg::LoadRam, cuPkg::LoadMdr:
				ctrl.mdrSel = `CU_MDR_RAM;
			cuPkg::LoadWrite:
			begin
				ctrl.regC    = fields.rd;
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_MDR;   // r0 + MDR
			end
			cuPkg::StoreData, cuPkg::StoreMdr:
			begin
				ctrl.regA    = fields.rd;   // Store data source
				ctrl.aluASel = `CU_ALUA_REGA;
				ctrl.aluBSel = `CU_ALUB_REGB;
				ctrl.mdrSel  = `CU_MDR_ALU;
			end
			default: ;
		endcase

		if (state inside {cuPkg::LoadImm, cuPkg::LoadReg, cuPkg::LoadImmMar, cuPkg::LoadRegMar,
			cuPkg::LoadRam, cuPkg::LoadMdr, cuPkg::LoadWrite, cuPkg::StoreImm, cuPkg::StoreReg,
			cuPkg::StoreImmMar, cuPkg::StoreRegMar, cuPkg::StoreData, cuPkg::StoreMdr,
			cuPkg::StoreRam})
			ctrl.ramOpcode = fields.op3;   // Size and sign of the access

		// Each strobe has one owner state
		case (state)
			cuPkg::Init:
			begin
				ctrl.pcClear  = 1'b1;
				ctrl.psrClear = 1'b1;
			end
			cuPkg::InitNpc, cuPkg::BrAnnulNpc, cuPkg::BrAnnulNpc2, cuPkg::BrSkipNpc,
			cuPkg::CallNpc, cuPkg::JmplImmNpc, cuPkg::JmplRegNpc:
				ctrl.npcEnable = 1'b1;
			cuPkg::MarLoad, cuPkg::LoadImmMar, cuPkg::LoadRegMar, cuPkg::StoreImmMar,
			cuPkg::StoreRegMar:
				ctrl.marEnable = 1'b1;
			cuPkg::RamStart, cuPkg::WaitMfc, cuPkg::LoadRam, cuPkg::StoreRam:
				ctrl.ramEnable = 1'b1;   // Held through the MFC wait
			cuPkg::IrLoad:
				ctrl.irEnable = 1'b1;
			cuPkg::PcAdvLoad, cuPkg::BrTakenLoad:
			begin
				ctrl.pcEnable  = 1'b1;
				ctrl.npcEnable = 1'b1;
			end
			cuPkg::BrAnnulPc, cuPkg::BrSkipPc, cuPkg::JmplPc:
				ctrl.pcEnable = 1'b1;
			cuPkg::CallLoad:
			begin
				ctrl.pcEnable = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			cuPkg::SethiWrite, cuPkg::JmplWrite, cuPkg::LoadWrite:
				ctrl.regWrite = 1'b1;
			cuPkg::ArithImmWrite, cuPkg::ArithRegWrite:
			begin
				ctrl.regWrite  = 1'b1;
				ctrl.psrEnable = fields.ccWrite;   // Flags only for the cc forms
			end
			cuPkg::LoadMdr, cuPkg::StoreMdr:
				ctrl.mdrEnable = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== rtl/controlSequencer.sv ====
module controlSequencer (
	input  logic              Clk,
	input  logic              RESET,
	input  cuPkg::instClass_t instClass,
	input  logic              immediate,
	input  logic              annul,
	input  logic              mfc,
	input  logic              cond,
	input  logic              branchAlways,
	input  logic              branchNever,
	output cuPkg::cuState_t   state
);

	cuPkg::cuState_t nextState;

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= cuPkg::Init;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = cuPkg::Init;
		case (state)
			cuPkg::Init:        nextState = cuPkg::InitCalc;
			cuPkg::InitCalc:    nextState = cuPkg::InitNpc;
			cuPkg::InitNpc:     nextState = cuPkg::FetchAddr;

			cuPkg::FetchAddr:   nextState = cuPkg::MarLoad;
			cuPkg::MarLoad:     nextState = cuPkg::RamStart;
			cuPkg::RamStart:    nextState = cuPkg::WaitMfc;
			cuPkg::WaitMfc:     nextState = mfc ? cuPkg::IrLoad : cuPkg::WaitMfc;
			cuPkg::IrLoad:      nextState = cuPkg::Decode;

			cuPkg::Decode:
			begin
				case (instClass)
					cuPkg::Sethi:  nextState = cuPkg::SethiCalc;
					cuPkg::Branch: nextState = cuPkg::BranchEval;
					cuPkg::Call:   nextState = cuPkg::CallCalc;
					cuPkg::Jmpl:   nextState = cuPkg::JmplLink;
					cuPkg::Arith:  nextState = immediate ? cuPkg::ArithImm : cuPkg::ArithReg;
					cuPkg::Load:   nextState = immediate ? cuPkg::LoadImm : cuPkg::LoadReg;
					cuPkg::Store:  nextState = immediate ? cuPkg::StoreImm : cuPkg::StoreReg;
					default:       nextState = cuPkg::PcAdvCalc;   // No-op
				endcase
			end

			// Shared PC/nPC advance
			cuPkg::PcAdvCalc:   nextState = cuPkg::PcAdvLoad;
			cuPkg::PcAdvLoad:   nextState = cuPkg::FetchAddr;

			cuPkg::SethiCalc:   nextState = cuPkg::SethiWrite;
			cuPkg::SethiWrite:  nextState = cuPkg::PcAdvCalc;

			cuPkg::BranchEval:
			begin
				if (cond)
				begin
					if (branchAlways)
						nextState = annul ? cuPkg::BrAnnulCalc : cuPkg::BrTakenCalc;
					else if (branchNever)
						nextState = annul ? cuPkg::BrAnnulCalc : cuPkg::PcAdvCalc;
					else
						nextState = cuPkg::BrTakenCalc;   // Delay slot always executes
				end
				else
					nextState = annul ? cuPkg::BrAnnulCalc : cuPkg::BrSkipPc;
			end
			cuPkg::BrTakenCalc: nextState = cuPkg::BrTakenLoad;
			cuPkg::BrTakenLoad: nextState = cuPkg::FetchAddr;
			// Annul skips the delay slot
			cuPkg::BrAnnulCalc: nextState = cuPkg::BrAnnulNpc;
			cuPkg::BrAnnulNpc:  nextState = cuPkg::BrAnnulPc;
			cuPkg::BrAnnulPc:   nextState = cuPkg::BrAnnulNpc2;
			cuPkg::BrAnnulNpc2: nextState = cuPkg::FetchAddr;
			cuPkg::BrSkipPc:    nextState = cuPkg::BrSkipNpc;
			cuPkg::BrSkipNpc:   nextState = cuPkg::FetchAddr;

			cuPkg::CallCalc:    nextState = cuPkg::CallLoad;
			cuPkg::CallLoad:    nextState = cuPkg::CallTarget;
			cuPkg::CallTarget:  nextState = cuPkg::CallNpc;
			cuPkg::CallNpc:     nextState = cuPkg::FetchAddr;

			cuPkg::JmplLink:    nextState = cuPkg::JmplWrite;
			cuPkg::JmplWrite:   nextState = cuPkg::JmplPc;
			cuPkg::JmplPc:      nextState = immediate ? cuPkg::JmplImm : cuPkg::JmplReg;
			cuPkg::JmplImm:     nextState = cuPkg::JmplImmNpc;
			cuPkg::JmplReg:     nextState = cuPkg::JmplRegNpc;
			cuPkg::JmplImmNpc:  nextState = cuPkg::FetchAddr;
			cuPkg::JmplRegNpc:  nextState = cuPkg::FetchAddr;

			cuPkg::ArithImm:      nextState = cuPkg::ArithImmWrite;
			cuPkg::ArithReg:      nextState = cuPkg::ArithRegWrite;
			cuPkg::ArithImmWrite: nextState = cuPkg::PcAdvCalc;
			cuPkg::ArithRegWrite: nextState = cuPkg::PcAdvCalc;

			cuPkg::LoadImm:     nextState = cuPkg::LoadImmMar;
			cuPkg::LoadReg:     nextState = cuPkg::LoadRegMar;
			cuPkg::LoadImmMar:  nextState = cuPkg::LoadRam;
			cuPkg::LoadRegMar:  nextState = cuPkg::LoadRam;
			cuPkg::LoadRam:     nextState = cuPkg::LoadMdr;
			cuPkg::LoadMdr:     nextState = cuPkg::LoadWrite;
			cuPkg::LoadWrite:   nextState = cuPkg::PcAdvCalc;

			cuPkg::StoreImm:    nextState = cuPkg::StoreImmMar;
			cuPkg::StoreReg:    nextState = cuPkg::StoreRegMar;
			cuPkg::StoreImmMar: nextState = cuPkg::StoreData;
			cuPkg::StoreRegMar: nextState = cuPkg::StoreData;
			cuPkg::StoreData:   nextState = cuPkg::StoreMdr;   // rd onto the ALU path
			cuPkg::StoreMdr:    nextState = cuPkg::StoreRam;
			cuPkg::StoreRam:    nextState = cuPkg::PcAdvCalc;

			default:            nextState = cuPkg::Init;
		endcase
	end

endmodule

// ==== rtl/instrDecoder.sv ====
`include "cu_defs.svh"

module instrDecoder (
	input  cuPkg::word_t       irOut,
	output cuPkg::instFields_t fields,
	output cuPkg::instClass_t  instClass
);

	logic [1:0] op;
	logic [2:0] op2;

	assign op  = irOut[31:30];
	assign op2 = irOut[24:22];   // Format 2 only

	assign fields.rd        = irOut[29:25];
	assign fields.rs1       = irOut[18:14];
	assign fields.rs2       = irOut[4:0];
	assign fields.op3       = irOut[24:19];
	assign fields.immediate = irOut[13];
	assign fields.annul     = irOut[29];
	assign fields.ccWrite   = irOut[23];   // The cc variants of arith ops

	always_comb
	begin
		case (op)
			2'b00:
				instClass = (op2 == `CU_OP2_SETHI) ? cuPkg::Sethi : cuPkg::Branch;
			2'b01:
				instClass = cuPkg::Call;
			2'b10:
				instClass = (fields.op3 == `CU_OP3_JMPL) ? cuPkg::Jmpl : cuPkg::Arith;
			default:
			begin
				// Memory format
				case (fields.op3)
					6'b000000, 6'b000001, 6'b000010, 6'b001001, 6'b001010:
						instClass = cuPkg::Load;
					6'b000100, 6'b000101, 6'b000110:
						instClass = cuPkg::Store;
					default:
						instClass = cuPkg::Nop;   // Doubles, swap and the rest
				endcase
			end
		endcase
	end

endmodule

// ==== rtl/cuPkg.sv ====
`include "cu_defs.svh"

package cuPkg;

	typedef logic [`CU_WORD_W-1:0]     word_t;
	typedef logic [`CU_REG_ADDR_W-1:0] regAddr_t;
	typedef logic [`CU_OP3_W-1:0]      op3_t;
	typedef logic [1:0]                aluASel_t;
	typedef logic [2:0]                aluBSel_t;
	typedef logic [2:0]                extSel_t;
	typedef logic [1:0]                pcInSel_t;

	typedef enum logic [2:0] {
		Sethi, Branch, Call, Jmpl, Arith, Load, Store, Nop
	} instClass_t;

	// Decoded instruction word
	typedef struct packed {
		regAddr_t rd;
		regAddr_t rs1;
		regAddr_t rs2;
		op3_t     op3;
		logic     immediate;
		logic     annul;   // Shares bit 29 with rd
		logic     ccWrite;
	} instFields_t;

	typedef enum logic [5:0] {
		Init, InitCalc, InitNpc,
		FetchAddr, MarLoad, RamStart, WaitMfc, IrLoad, Decode,
		PcAdvCalc, PcAdvLoad,
		SethiCalc, SethiWrite,
		BranchEval, BrTakenCalc, BrTakenLoad,
		BrAnnulCalc, BrAnnulNpc, BrAnnulPc, BrAnnulNpc2,
		BrSkipPc, BrSkipNpc,
		CallCalc, CallLoad, CallTarget, CallNpc,
		JmplLink, JmplWrite, JmplPc, JmplImm, JmplReg, JmplImmNpc, JmplRegNpc,
		ArithImm, ArithReg, ArithImmWrite, ArithRegWrite,
		LoadImm, LoadReg, LoadImmMar, LoadRegMar, LoadRam, LoadMdr, LoadWrite,
		StoreImm, StoreReg, StoreImmMar, StoreRegMar, StoreData, StoreMdr, StoreRam
	} cuState_t;

	typedef struct packed {
		logic     irEnable;
		logic     npcEnable;
		logic     pcEnable;
		logic     mdrEnable;
		logic     marEnable;
		logic     regWrite;
		logic     ramEnable;
		logic     psrEnable;
		logic     pcClear;
		logic     psrClear;
		aluASel_t aluASel;
		aluBSel_t aluBSel;
		extSel_t  extSel;
		pcInSel_t pcInSel;
		logic     mdrSel;   // RAM or ALU into MDR
		regAddr_t regC;     // Write port
		regAddr_t regA;
		regAddr_t regB;
		op3_t     aluOp;
		op3_t     ramOpcode;
	} ctrlWord_t;

endpackage

// ==== rtl/cu_defs.svh ====
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// Datapath and instruction field widths
`define CU_WORD_W      32
`define CU_REG_ADDR_W  5
`define CU_OP3_W       6

`define CU_ZERO_REG    5'd0
`define CU_LINK_REG    5'd15   // Return address of CALL

`define CU_ALU_ADD        6'b000000
`define CU_RAM_LOAD_WORD  6'b000000   // Instruction fetch
`define CU_OP3_JMPL       6'b111000
`define CU_OP2_SETHI      3'b100

// ALU operand A sources
`define CU_ALUA_REGA   2'b00
`define CU_ALUA_PC     2'b01
`define CU_ALUA_NPC    2'b10

// ALU operand B sources
`define CU_ALUB_REGB   3'b000
`define CU_ALUB_EXT    3'b001
`define CU_ALUB_MDR    3'b010
`define CU_ALUB_PC     3'b011
`define CU_ALUB_FOUR   3'b110

// Immediate extender modes
`define CU_EXT_SIMM13  3'b000
`define CU_EXT_DISP30  3'b011   // Word displacement shifted by two
`define CU_EXT_IMM22   3'b100
`define CU_EXT_DISP22  3'b101

`define CU_PCIN_NPC    2'b00
`define CU_MDR_ALU     1'b0
`define CU_MDR_RAM     1'b1

`endif
